// ==== mps_cfg.svh ====
`ifndef MPS_CFG_SVH
`define MPS_CFG_SVH

// Step timing in clock cycles, kept short for simulation
`define MPS_HOLD_CYCLES      16
`define MPS_TIMEOUT_CYCLES   64
`define MPS_OFF_HOLD_CYCLES  8

// Consecutive high samples before the interlock counts
`define MPS_INTL_FILT        3

// DC-link thresholds as IEEE single-precision words
`define MPS_DC_ON_LIMIT      32'h438C_0000 // 280.0
`define MPS_DC_OFF_LIMIT     32'h4120_0000 // 10.0

// APB register offsets
`define MPS_ADDR_CTRL        8'h00
`define MPS_ADDR_DCV         8'h04
`define MPS_ADDR_STAT        8'h08
`define MPS_ADDR_DI          8'h0C

`endif

// ==== mps_seq_pkg.sv ====
package mps_seq_pkg;

	typedef enum logic [3:0] {
		IDLE          = 4'd0,
		CLR           = 4'd1,
		DISCHA_CHK    = 4'd4,
		DISCHA_DONE   = 4'd5,
		SLOW_ON_CHK   = 4'd6,
		SLOW_ON_DONE  = 4'd7,
		DC_CHK        = 4'd8,
		DC_DONE       = 4'd9,
		MAIN_CHK      = 4'd10,
		MAIN_DONE     = 4'd11,
		SLOW_OFF_CHK  = 4'd12,
		SLOW_OFF_DONE = 4'd13,
		SYSTEM_ON     = 4'd14,
		FAIL          = 4'd15
	} on_state_e; // CHK states are even, DONE states odd

	typedef enum logic [1:0] {
		OFF_IDLE   = 2'd0,
		MAIN_OFF   = 2'd1,
		DISCHA_ON  = 2'd2,
		SYSTEM_OFF = 2'd3
	} off_state_e;

	typedef struct packed {
		logic        sign;
		logic [7:0]  exp;
		logic [22:0] man;
	} fp32_fields_t;

	typedef union packed {
		logic [31:0]  word;
		fp32_fields_t f;
	} fp32_u;

endpackage

// ==== mps_bus_pkg.sv ====
package mps_bus_pkg;

	typedef struct packed {
		logic [6:0] rsv3;
		logic       intl;
		logic [3:0] rsv2;
		logic [3:0] fail_step;
		logic [5:0] rsv1;
		logic [1:0] off_state;
		logic [3:0] rsv0;
		logic [3:0] on_state;
	} mps_stat_t;

	typedef struct packed {
		logic [29:0] rsv;
		logic        pwr_off;
		logic        pwr_on;
	} mps_cmd_t;

endpackage

// ==== mps_seq_if.sv ====
`timescale 1ns/10ps

interface mps_seq_if
	import mps_seq_pkg::*;
();
	logic       on_req;    // One-cycle command pulses
	logic       off_req;
	fp32_u      dc_v;
	on_state_e  on_state;
	off_state_e off_state;
	logic [3:0] fail_step;

	modport regs (output on_req, output off_req, output dc_v,
		input on_state, input off_state, input fail_step);

	modport seq (input on_req, input off_req, input dc_v,
		output on_state, output off_state, output fail_step);
endinterface

// ==== mps_di_sync.sv ====
`timescale 1ns/10ps
`include "mps_cfg.svh"

module mps_di_sync
(
	input  logic        i_clk,
	input  logic        i_rst,
	input  logic [15:0] i_ext_di,
	input  logic        i_intl,
	output logic [15:0] o_di,
	output logic        o_intl
);
	localparam int FILT = `MPS_INTL_FILT;
	localparam int CW   = $clog2(FILT + 1);

	logic [15:0]   di_s1;
	logic          intl_s1;
	logic          intl_s2;
	logic [CW-1:0] intl_cnt;
	logic          intl_sat;

	assign intl_sat = (intl_cnt == CW'(FILT - 1));

	always_ff @(posedge i_clk or negedge i_rst)
	begin
		if (!i_rst)
		begin
			di_s1    <= '0;
			o_di     <= '0;
			intl_s1  <= 1'b0;
			intl_s2  <= 1'b0;
			intl_cnt <= '0;
			o_intl   <= 1'b0;
		end
		else
		begin
			di_s1    <= i_ext_di;
			o_di     <= di_s1;
			intl_s1  <= i_intl;
			intl_s2  <= intl_s1;
			intl_cnt <= !intl_s2 ? '0 : (intl_sat ? intl_cnt : intl_cnt + 1'b1);
			o_intl   <= intl_s2 && intl_sat; // A single low sample drops it
		end
	end
endmodule

// ==== fp32_cmp_gt.sv ====
`timescale 1ns/10ps

module fp32_cmp_gt
	import mps_seq_pkg::*;
(
	input  logic  i_clk,
	input  logic  i_rst,
	input  logic  i_valid,
	input  fp32_u i_a,
	input  fp32_u i_b,
	output logic  o_valid,
	output logic  o_gt
);
	logic [30:0] mag_a;
	logic [30:0] mag_b;
	logic        s1_valid;
	logic        s1_mag_gt;
	logic        s1_mag_lt;
	logic        s1_sign_a;
	logic        s1_sign_b;
	logic        s1_zero;

	assign mag_a = {i_a.f.exp, i_a.f.man};
	assign mag_b = {i_b.f.exp, i_b.f.man};

	always_ff @(posedge i_clk or negedge i_rst)
	begin
		if (!i_rst)
		begin
			s1_valid <= 1'b0;
			o_valid  <= 1'b0;
		end
		else
		begin
			s1_valid <= i_valid;
			o_valid  <= s1_valid;
		end
	end

	always_ff @(posedge i_clk)
	begin
		s1_mag_gt <= (mag_a > mag_b);
		s1_mag_lt <= (mag_a < mag_b);
		s1_sign_a <= i_a.f.sign;
		s1_sign_b <= i_b.f.sign;
		s1_zero   <= (mag_a == '0) && (mag_b == '0); // Signed zeros compare equal

		if (s1_zero)
			o_gt <= 1'b0;
		else if (s1_sign_a != s1_sign_b)
			o_gt <= !s1_sign_a;
		else if (!s1_sign_a)
			o_gt <= s1_mag_gt;
		else
			o_gt <= s1_mag_lt; // Both negative so the smaller magnitude wins
	end
endmodule

// ==== mps_op_fsm.sv ====
`timescale 1ns/10ps
`include "mps_cfg.svh"

module mps_op_fsm
	import mps_seq_pkg::*;
(
	input  logic        i_clk,
	input  logic        i_rst,
	mps_seq_if.seq      seq,
	input  logic [15:0] i_di,
	input  logic        i_intl
);
	localparam int HOLD     = `MPS_HOLD_CYCLES;
	localparam int TIMEOUT  = `MPS_TIMEOUT_CYCLES;
	localparam int OFF_HOLD = `MPS_OFF_HOLD_CYCLES;
	localparam int HOLD_W   = $clog2(HOLD + 1);
	localparam int TO_W     = $clog2(TIMEOUT + 1);
	localparam int OFF_W    = $clog2(OFF_HOLD + 1);

	localparam fp32_u DC_ON_LIM  = `MPS_DC_ON_LIMIT;
	localparam fp32_u DC_OFF_LIM = `MPS_DC_OFF_LIMIT;

	on_state_e      on_state;
	on_state_e      n_on_state;
	off_state_e     off_state;
	off_state_e     n_off_state;
	logic [HOLD_W-1:0] on_hold_cnt;
	logic [OFF_W-1:0]  off_hold_cnt;
	logic [TO_W-1:0]   timeout_cnt;
	logic [3:0]     fail_step;
	logic           step_chk;
	logic           hold_sat;
	logic           off_hold_sat;
	logic           timeout_hit;
	logic           dc_on_valid;
	logic           dc_on_gt;
	logic           dc_off_valid;
	logic           dc_off_gt;

	assign step_chk     = !on_state[0] && (on_state >= DISCHA_CHK) && (on_state <= SLOW_OFF_CHK);
	assign hold_sat     = (on_hold_cnt == HOLD_W'(HOLD - 1));
	assign off_hold_sat = (off_hold_cnt == OFF_W'(OFF_HOLD - 1));
	assign timeout_hit  = (timeout_cnt == TO_W'(TIMEOUT));

	always_comb
	begin
		case (on_state)
			IDLE          : n_on_state = seq.on_req ? CLR : IDLE;
			CLR           : n_on_state = DISCHA_CHK;
			DISCHA_CHK    : n_on_state = (hold_sat && !i_di[3]) ? DISCHA_DONE : DISCHA_CHK;
			DISCHA_DONE   : n_on_state = SLOW_ON_CHK;
			SLOW_ON_CHK   : n_on_state = (hold_sat && i_di[2]) ? SLOW_ON_DONE : SLOW_ON_CHK;
			SLOW_ON_DONE  : n_on_state = DC_CHK;
			DC_CHK        : n_on_state = (dc_on_valid && dc_on_gt) ? DC_DONE : DC_CHK;
			DC_DONE       : n_on_state = MAIN_CHK;
			MAIN_CHK      : n_on_state = (hold_sat && i_di[1]) ? MAIN_DONE : MAIN_CHK;
			MAIN_DONE     : n_on_state = SLOW_OFF_CHK;
			SLOW_OFF_CHK  : n_on_state = (hold_sat && !i_di[2]) ? SLOW_OFF_DONE : SLOW_OFF_CHK;
			SLOW_OFF_DONE : n_on_state = SYSTEM_ON;
			SYSTEM_ON     : n_on_state = (off_state == SYSTEM_OFF) ? IDLE : SYSTEM_ON;
			default       : n_on_state = IDLE; // FAIL always returns to IDLE
		endcase

		if ((i_intl || timeout_hit) && (on_state != IDLE) && (on_state != FAIL))
			n_on_state = FAIL;
	end

	always_comb
	begin
		case (off_state)
			OFF_IDLE  : n_off_state = seq.off_req ? MAIN_OFF : OFF_IDLE;
			MAIN_OFF  : n_off_state = off_hold_sat ? DISCHA_ON : MAIN_OFF;
			DISCHA_ON : n_off_state = (dc_off_valid && dc_off_gt) ? SYSTEM_OFF : DISCHA_ON;
			default   : n_off_state = OFF_IDLE;
		endcase
	end

	always_ff @(posedge i_clk or negedge i_rst)
	begin
		if (!i_rst)
		begin
			on_state     <= IDLE;
			off_state    <= OFF_IDLE;
			on_hold_cnt  <= '0;
			off_hold_cnt <= '0;
			timeout_cnt  <= '0;
		end
		else
		begin
			on_state     <= n_on_state;
			off_state    <= n_off_state;
			on_hold_cnt  <= !step_chk ? '0 : (hold_sat ? on_hold_cnt : on_hold_cnt + 1'b1);
			off_hold_cnt <= ((off_state == MAIN_OFF) && !off_hold_sat) ? off_hold_cnt + 1'b1 : '0;
			// Runs only once the hold has elapsed and the step is still waiting
			timeout_cnt  <= (step_chk && hold_sat && (n_on_state == on_state)) ?
				timeout_cnt + 1'b1 : '0;
		end
	end

	always_ff @(posedge i_clk or negedge i_rst)
	begin
		if (!i_rst)
			fail_step <= '0;
		else if (on_state == CLR)
			fail_step <= '0;
		else if ((on_state != FAIL) && (on_state > fail_step))
			fail_step <= on_state;
	end

	fp32_cmp_gt u_cmp_on
	(
		.i_clk   (i_clk),
		.i_rst   (i_rst),
		.i_valid (on_state == DC_CHK),
		.i_a     (seq.dc_v),
		.i_b     (DC_ON_LIM),
		.o_valid (dc_on_valid),
		.o_gt    (dc_on_gt)
	);

	fp32_cmp_gt u_cmp_off
	(
		.i_clk   (i_clk),
		.i_rst   (i_rst),
		.i_valid (off_state == DISCHA_ON),
		.i_a     (DC_OFF_LIM),
		.i_b     (seq.dc_v),
		.o_valid (dc_off_valid),
		.o_gt    (dc_off_gt)
	);

	assign seq.on_state  = on_state;
	assign seq.off_state = off_state;
	assign seq.fail_step = fail_step;
endmodule

// ==== mps_apb_regs.sv ====
`timescale 1ns/10ps
`include "mps_cfg.svh"

module mps_apb_regs
	import mps_bus_pkg::*;
(
	input  logic        i_clk,
	input  logic        i_rst,
	input  logic        i_psel,
	input  logic        i_penable,
	input  logic        i_pwrite,
	input  logic [7:0]  i_paddr,
	input  logic [31:0] i_pwdata,
	output logic [31:0] o_prdata,
	output logic        o_pready,
	output logic        o_pslverr,
	mps_seq_if.regs     seq,
	input  logic [15:0] i_di,
	input  logic        i_intl
);
	logic        access;
	logic        wr_access;
	logic        hit_ctrl;
	logic        hit_dcv;
	logic        hit_stat;
	logic        hit_di;
	logic        on_req;
	logic        off_req;
	logic [31:0] dc_v;
	mps_cmd_t    wr_cmd;
	mps_stat_t   stat;

	assign access    = i_psel && i_penable;
	assign wr_access = access && i_pwrite;
	assign hit_ctrl  = (i_paddr == `MPS_ADDR_CTRL);
	assign hit_dcv   = (i_paddr == `MPS_ADDR_DCV);
	assign hit_stat  = (i_paddr == `MPS_ADDR_STAT);
	assign hit_di    = (i_paddr == `MPS_ADDR_DI);
	assign wr_cmd    = i_pwdata;

	assign o_pready  = access; // Every access completes in one cycle
	assign o_pslverr = access && (!(hit_ctrl || hit_dcv || hit_stat || hit_di) ||
		(i_pwrite && (hit_stat || hit_di)));

	always_ff @(posedge i_clk or negedge i_rst)
	begin
		if (!i_rst)
		begin
			on_req  <= 1'b0;
			off_req <= 1'b0;
			dc_v    <= '0;
		end
		else
		begin
			on_req  <= wr_access && hit_ctrl && wr_cmd.pwr_on;
			off_req <= wr_access && hit_ctrl && wr_cmd.pwr_off;
			if (wr_access && hit_dcv)
				dc_v <= i_pwdata;
		end
	end

	always_comb
	begin
		stat           = '0;
		stat.on_state  = seq.on_state;
		stat.off_state = seq.off_state;
		stat.fail_step = seq.fail_step;
		stat.intl      = i_intl;

		o_prdata = '0;
		if (hit_dcv)
			o_prdata = dc_v;
		else if (hit_stat)
			o_prdata = stat;
		else if (hit_di)
			o_prdata = {16'h0000, i_di};
	end

	assign seq.on_req  = on_req;
	assign seq.off_req = off_req;
	assign seq.dc_v.word = dc_v;
endmodule

// ==== mps_top.sv ====
`timescale 1ns/10ps

module mps_top
(
	input  logic        i_clk,
	input  logic        i_rst,
	input  logic        i_psel,
	input  logic        i_penable,
	input  logic        i_pwrite,
	input  logic [7:0]  i_paddr,
	input  logic [31:0] i_pwdata,
	output logic [31:0] o_prdata,
	output logic        o_pready,
	output logic        o_pslverr,
	input  logic [15:0] i_ext_di,
	input  logic        i_intl,
	output logic [3:0]  o_on_state,
	output logic [1:0]  o_off_state,
	output logic [3:0]  o_fail_step
);
	logic [15:0] di_sync;
	logic        intl_filt;

	mps_seq_if seq_bus ();

	mps_di_sync u_di_sync
	(
		.i_clk    (i_clk),
		.i_rst    (i_rst),
		.i_ext_di (i_ext_di),
		.i_intl   (i_intl),
		.o_di     (di_sync),
		.o_intl   (intl_filt)
	);

	mps_apb_regs u_apb_regs
	(
		.i_clk     (i_clk),
		.i_rst     (i_rst),
		.i_psel    (i_psel),
		.i_penable (i_penable),
		.i_pwrite  (i_pwrite),
		.i_paddr   (i_paddr),
		.i_pwdata  (i_pwdata),
		.o_prdata  (o_prdata),
		.o_pready  (o_pready),
		.o_pslverr (o_pslverr),
		.seq       (seq_bus.regs),
		.i_di      (di_sync),
		.i_intl    (intl_filt)
	);

	mps_op_fsm u_op_fsm
	(
		.i_clk  (i_clk),
		.i_rst  (i_rst),
		.seq    (seq_bus.seq),
		.i_di   (di_sync),
		.i_intl (intl_filt)
	);

	assign o_on_state  = seq_bus.on_state;
	assign o_off_state = seq_bus.off_state;
	assign o_fail_step = seq_bus.fail_step;
endmodule

// ==== mps_chk.sv ====
`timescale 1ns/10ps

module mps_chk
	import mps_seq_pkg::*;
(
	input logic       i_clk,
	input logic       i_rst,
	input logic [3:0] i_on_state,
	input logic [1:0] i_off_state,
	input logic [3:0] i_fail_step,
	input logic       i_intl
);
	a_fail_then_idle : assert property (@(posedge i_clk) disable iff (!i_rst)
		(i_on_state == FAIL) |=> (i_on_state == IDLE))
		else $error("On-state left FAIL for a state other than IDLE");

	// The filtered interlock forces FAIL on the next edge
	a_no_on_with_intl : assert property (@(posedge i_clk) disable iff (!i_rst)
		i_intl |=> (i_on_state != SYSTEM_ON))
		else $error("SYSTEM_ON seen while the interlock is active");

	a_fail_step_range : assert property (@(posedge i_clk) disable iff (!i_rst)
		(i_fail_step != 4'd15))
		else $error("Fail step recorded the FAIL code");

	a_off_ends_on : assert property (@(posedge i_clk) disable iff (!i_rst)
		((i_off_state == SYSTEM_OFF) && (i_on_state == SYSTEM_ON)) |=> (i_on_state == IDLE))
		else $error("SYSTEM_OFF did not return the on-state to IDLE");
endmodule

bind mps_op_fsm mps_chk u_chk
(
	.i_clk       (i_clk),
	.i_rst       (i_rst),
	.i_on_state  (on_state),
	.i_off_state (off_state),
	.i_fail_step (fail_step),
	.i_intl      (i_intl)
);

// ==== tb_mps.sv ====
`timescale 1ns/10ps
`include "mps_cfg.svh"

module tb_mps
	import mps_seq_pkg::*;
();
	localparam int PERIOD     = 100;
	localparam int MAX_CYCLES = 4000;
	localparam int HOLD       = `MPS_HOLD_CYCLES;
	localparam int TIMEOUT    = `MPS_TIMEOUT_CYCLES;
	localparam int OFF_HOLD   = `MPS_OFF_HOLD_CYCLES;
	localparam int STEP_LIMIT = HOLD + TIMEOUT + 20; // Longest wait for one step

	localparam logic [31:0] FP_300 = 32'h4396_0000;
	localparam logic [31:0] FP_50  = 32'h4248_0000;
	localparam logic [31:0] FP_5   = 32'h40A0_0000;

	logic        i_clk = 1'b0;
	logic        i_rst;
	logic        i_psel;
	logic        i_penable;
	logic        i_pwrite;
	logic [7:0]  i_paddr;
	logic [31:0] i_pwdata;
	logic [31:0] o_prdata;
	logic        o_pready;
	logic        o_pslverr;
	logic [15:0] i_ext_di;
	logic        i_intl;
	logic [3:0]  o_on_state;
	logic [1:0]  o_off_state;
	logic [3:0]  o_fail_step;

	int     errors = 0;
	int     checks = 0;
	int     tests  = 0;
	int     cycles = 0;
	integer seed   = 89;

	mps_top DUT
	(
		.i_clk       (i_clk),
		.i_rst       (i_rst),
		.i_psel      (i_psel),
		.i_penable   (i_penable),
		.i_pwrite    (i_pwrite),
		.i_paddr     (i_paddr),
		.i_pwdata    (i_pwdata),
		.o_prdata    (o_prdata),
		.o_pready    (o_pready),
		.o_pslverr   (o_pslverr),
		.i_ext_di    (i_ext_di),
		.i_intl      (i_intl),
		.o_on_state  (o_on_state),
		.o_off_state (o_off_state),
		.o_fail_step (o_fail_step)
	);

	always #(PERIOD/2) i_clk = ~i_clk;

	always @(posedge i_clk)
	begin
		cycles <= cycles + 1;
		if (cycles >= MAX_CYCLES)
		begin
			$display("Run stopped after %0d cycles with tests still running", cycles);
			$display("Result: FAILED");
			$finish;
		end
	end

	// Sign and magnitude map onto one signed line, so both zeros land on 0
	function automatic bit fp_above(input logic [31:0] a, input logic [31:0] b);
		longint ka;
		longint kb;
		ka = a[31] ? -longint'(a[30:0]) : longint'(a[30:0]);
		kb = b[31] ? -longint'(b[30:0]) : longint'(b[30:0]);
		return ka > kb;
	endfunction

	task automatic expect_eq(input logic [31:0] got, input logic [31:0] exp, input string what);
		checks++;
		assert (got === exp)
		else
		begin
			$display("MISMATCH at %0t ns: %s is %0h, expected %0h", $time, what, got, exp);
			errors++;
		end
	endtask

	task automatic apb_access(input logic wr, input logic [7:0] addr, input logic [31:0] wdata,
		output logic [31:0] rdata, output logic err);
		@(negedge i_clk);
		i_psel    = 1'b1;
		i_penable = 1'b0;
		i_pwrite  = wr;
		i_paddr   = addr;
		i_pwdata  = wdata;
		@(negedge i_clk);
		i_penable = 1'b1;
		#(PERIOD/4);
		expect_eq(o_pready, 1'b1, "pready in access phase");
		rdata = o_prdata;
		err   = o_pslverr;
		@(negedge i_clk);
		i_psel    = 1'b0;
		i_penable = 1'b0;
		i_pwrite  = 1'b0;
	endtask

	task automatic write_reg(input logic [7:0] addr, input logic [31:0] data);
		logic [31:0] rd;
		logic        err;
		apb_access(1'b1, addr, data, rd, err);
		expect_eq(err, 1'b0, $sformatf("pslverr on write to %0h", addr));
	endtask

	task automatic read_check(input logic [7:0] addr, input logic [31:0] exp, input string what);
		logic [31:0] rd;
		logic        err;
		apb_access(1'b0, addr, 32'h0, rd, err);
		expect_eq(err, 1'b0, $sformatf("pslverr on read of %0h", addr));
		expect_eq(rd, exp, what);
	endtask

	task automatic wait_state(input bit off_seq, input logic [3:0] code, input int limit,
		output int n);
		bit found;
		n     = 0;
		found = 1'b0;
		while (!found && (n < limit))
		begin
			@(negedge i_clk);
			n++;
			found = off_seq ? (o_off_state == code[1:0]) : (o_on_state == code);
		end
		checks++;
		assert (found)
		else
		begin
			$display("Waited %0d cycles up to %0t ns for %s-state %0d, which never came",
				limit, $time, off_seq ? "off" : "on", code);
			errors++;
		end
	endtask

	task automatic report_test(input string name, input int errs_before);
		tests++;
		if (errors == errs_before)
			$display("Test %-18s finished without errors", name);
		else
			$display("Test %-18s finished with %0d errors", name, errors - errs_before);
	endtask

	task automatic check_register_map();
		int          e0;
		logic [31:0] rd;
		logic        err;
		e0 = errors;
		expect_eq(o_pslverr, 1'b0, "pslverr after reset");
		read_check(`MPS_ADDR_STAT, 32'h0, "STAT after reset");
		write_reg(`MPS_ADDR_DCV, 32'h1234_5678);
		read_check(`MPS_ADDR_DCV, 32'h1234_5678, "DCV readback");
		i_ext_di = 16'hA5F0;
		read_check(`MPS_ADDR_DI, 32'h0000_A5F0, "DI after two cycles");
		i_ext_di = 16'h0000;
		apb_access(1'b0, 8'h10, 32'h0, rd, err);
		expect_eq(err, 1'b1, "pslverr on unmapped read");
		apb_access(1'b1, 8'h14, 32'h1, rd, err);
		expect_eq(err, 1'b1, "pslverr on unmapped write");
		apb_access(1'b1, `MPS_ADDR_STAT, 32'hFFFF_FFFF, rd, err);
		expect_eq(err, 1'b1, "pslverr on STAT write");
		apb_access(1'b1, `MPS_ADDR_DI, 32'hFFFF_FFFF, rd, err);
		expect_eq(err, 1'b1, "pslverr on DI write");
		read_check(`MPS_ADDR_STAT, 32'h0, "STAT after rejected write");
		report_test("register_map", e0);
	endtask

	task automatic power_on_sequence();
		int         e0;
		int         n;
		logic [3:0] steps [12] = '{1, 4, 5, 6, 7, 8, 9, 10, 11, 12, 13, 14};
		e0 = errors;
		write_reg(`MPS_ADDR_DCV, FP_300);
		write_reg(`MPS_ADDR_CTRL, 32'h1);
		foreach (steps[i])
		begin
			wait_state(1'b0, steps[i], STEP_LIMIT, n);
			case (steps[i])
				SLOW_ON_CHK  : i_ext_di[2] = 1'b1; // Slow-charge contactor closes
				MAIN_CHK     : i_ext_di[1] = 1'b1;
				SLOW_OFF_CHK : i_ext_di[2] = 1'b0;
				default      : ;
			endcase
		end
		read_check(`MPS_ADDR_STAT, 32'h000E_000E, "STAT at SYSTEM_ON");
		expect_eq(o_fail_step, 4'd14, "fail step at SYSTEM_ON");
		report_test("power_on", e0);
	endtask

	task automatic power_off_sequence();
		int e0;
		int n;
		e0 = errors;
		write_reg(`MPS_ADDR_DCV, FP_50);
		write_reg(`MPS_ADDR_CTRL, 32'h2);
		wait_state(1'b1, MAIN_OFF, 4, n);
		wait_state(1'b1, DISCHA_ON, STEP_LIMIT, n);
		expect_eq(n, OFF_HOLD, "cycles in MAIN_OFF");
		repeat (10) @(negedge i_clk);
		expect_eq(o_off_state, DISCHA_ON, "off-state while DC link is high");
		expect_eq(o_on_state, SYSTEM_ON, "on-state while discharging");
		write_reg(`MPS_ADDR_DCV, FP_5);
		wait_state(1'b1, SYSTEM_OFF, 10, n);
		expect_eq(o_on_state, SYSTEM_ON, "on-state at SYSTEM_OFF");
		wait_state(1'b0, IDLE, 1, n);
		expect_eq(o_off_state, OFF_IDLE, "off-state after SYSTEM_OFF");
		report_test("power_off", e0);
	endtask

	task automatic interlock_trip();
		int e0;
		int n;
		e0 = errors;
		i_ext_di = 16'h0000;
		write_reg(`MPS_ADDR_CTRL, 32'h1);
		wait_state(1'b0, SLOW_ON_CHK, STEP_LIMIT, n);
		i_intl = 1'b1;
		wait_state(1'b0, FAIL, 12, n);
		wait_state(1'b0, IDLE, 1, n);
		expect_eq(o_fail_step, 4'd6, "fail step after interlock");
		i_intl = 1'b0;
		repeat (8) @(negedge i_clk);
		read_check(`MPS_ADDR_STAT, 32'h0006_0000, "STAT after interlock clears");
		report_test("interlock", e0);
	endtask

	task automatic step_timeout();
		int e0;
		int n;
		e0 = errors;
		i_ext_di[3] = 1'b1; // Discharge contactor stays closed
		write_reg(`MPS_ADDR_CTRL, 32'h1);
		wait_state(1'b0, DISCHA_CHK, 10, n);
		wait_state(1'b0, FAIL, STEP_LIMIT, n);
		expect_eq(n, HOLD + TIMEOUT, "cycles from DISCHA_CHK to FAIL");
		expect_eq(o_fail_step, 4'd4, "fail step after timeout");
		wait_state(1'b0, IDLE, 1, n);
		i_ext_di = 16'h0000;
		report_test("timeout", e0);
	endtask

	task automatic dc_threshold_sweep();
		int          e0;
		int          n;
		integer      r;
		logic [7:0]  exp_field;
		logic [31:0] word;
		bit          above;
		e0 = errors;
		i_ext_di = 16'h0004;
		for (int i = 0; i < 8; i++)
		begin
			r         = $random(seed);
			exp_field = 8'd128 + {4'd0, r[27:24]}; // Exponents around the 280 V limit
			word      = {r[31], exp_field, r[22:0]};
			above     = fp_above(word, `MPS_DC_ON_LIMIT);
			write_reg(`MPS_ADDR_DCV, word);
			write_reg(`MPS_ADDR_CTRL, 32'h1);
			wait_state(1'b0, DC_CHK, STEP_LIMIT, n);
			n = 0;
			while ((o_on_state == DC_CHK) && (n < STEP_LIMIT))
			begin
				@(negedge i_clk);
				n++;
			end
			expect_eq(o_on_state, above ? DC_DONE : FAIL, $sformatf("DC_CHK end for %h", word));
			if (!above)
				expect_eq(o_fail_step, 4'd8, $sformatf("fail step for %h", word));
			wait_state(1'b0, IDLE, 2 * STEP_LIMIT, n);
		end
		i_ext_di = 16'h0000;
		report_test("dc_threshold", e0);
	endtask

	initial
	begin
		i_rst     = 1'b0;
		i_psel    = 1'b0;
		i_penable = 1'b0;
		i_pwrite  = 1'b0;
		i_paddr   = 8'h00;
		i_pwdata  = 32'h0;
		i_ext_di  = 16'h0000;
		i_intl    = 1'b0;
		repeat (4) @(negedge i_clk);
		i_rst = 1'b1;

		check_register_map();
		power_on_sequence();
		power_off_sequence();
		interlock_trip();
		step_timeout();
		dc_threshold_sweep();

		$display("Tests: %0d, checks: %0d, errors: %0d", tests, checks, errors);
		if (errors == 0)
			$display("Result: PASSED");
		else
			$display("Result: FAILED");
		$finish;
	end
endmodule

// ==== sim.f ====
+incdir+.
mps_seq_pkg.sv
mps_bus_pkg.sv
mps_seq_if.sv
mps_di_sync.sv
fp32_cmp_gt.sv
mps_op_fsm.sv
mps_apb_regs.sv
mps_top.sv
mps_chk.sv
tb_mps.sv

// ==== run_sim.sh ====
#!/bin/sh
# Builds the testbench with Verilator, runs it and scans the log for a failure

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal --top-module tb_mps \
	-f sim.f -Mdir obj_dir -o sim_tb_mps
status=$?
if [ $status -ne 0 ]; then
	echo "Verilator build failed with status $status"
	exit 1
fi

./obj_dir/sim_tb_mps > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "Result: FAILED" "$LOG"; then
	exit 1
fi
exit 0
